//--- rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;

    // major opcodes handled by this core
    typedef enum logic [6:0] {
        op_op    = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // immediate formats widened in the exu
    typedef enum logic [1:0] {
        imm_none = 2'd0,
        imm_12i  = 2'd1,  // sign extended I-type
        imm_20u  = 2'd2,  // upper 20 bits
        imm_5u   = 2'd3   // shift amount
    } imm_sel_e;

    // first operand source with code 2'd3 spare
    typedef enum logic [1:0] {
        rs1_reg  = 2'd0,
        rs1_pc   = 2'd1,
        rs1_zero = 2'd2
    } rs1_sel_e;

    typedef enum logic {
        rs2_imm = 1'b0,
        rs2_reg = 1'b1
    } rs2_sel_e;

    // 10 bits of execute control
    typedef struct packed {
        alu_op_e  alu_op;
        imm_sel_e imm_sel;
        rs1_sel_e rs1_sel;
        rs2_sel_e rs2_sel;
        logic     reg_write;
    } ex_ctrl_t;

endpackage

//--- idu.sv
`timescale 1ns/1ps

module idu import rv_pkg::*; (
    input  logic [31:0] instr,
    output logic [4:0]  rs1_addr,
    output logic [4:0]  rs2_addr,
    output logic [4:0]  rd,
    output logic [19:0] imm,
    output ex_ctrl_t    ctrl,
    output logic        illegal
);

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        alt;     // instr[30] selects sub and sra
    alu_op_e     f3_op;

    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign alt      = instr[30];

    assign rd       = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // operation from funct3 alone
    always_comb begin
        case (funct3)
            3'b000:  f3_op = alu_add;
            3'b001:  f3_op = alu_sll;
            3'b010:  f3_op = alu_slt;
            3'b011:  f3_op = alu_sltu;
            3'b100:  f3_op = alu_xor;
            3'b101:  f3_op = alt ? alu_sra : alu_srl;
            3'b110:  f3_op = alu_or;
            default: f3_op = alu_and;
        endcase
    end

    always_comb begin
        ctrl.alu_op    = alu_add;
        ctrl.imm_sel   = imm_none;
        ctrl.rs1_sel   = rs1_reg;
        ctrl.rs2_sel   = rs2_reg;
        ctrl.reg_write = 1'b0;
        imm            = '0;
        illegal        = 1'b0;
        case (opcode)
            op_op: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = (funct3 == 3'b000 && alt) ? alu_sub : f3_op;
                // only add/sub and srl/sra know the alternate funct7
                if (funct7 != 7'b0000000 &&
                    !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    illegal = 1'b1;
                end
            end
            op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.rs2_sel   = rs2_imm;
                ctrl.alu_op    = f3_op;
                imm            = {8'd0, instr[31:20]};
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    ctrl.imm_sel = imm_5u;
                    if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000 && funct3 == 3'b101)) begin
                        illegal = 1'b1;
                    end
                end else begin
                    ctrl.imm_sel = imm_12i;
                end
            end
            op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.rs1_sel   = rs1_zero;
                ctrl.rs2_sel   = rs2_imm;
                ctrl.imm_sel   = imm_20u;
                imm            = instr[31:12];
            end
            op_auipc: begin
                ctrl.reg_write = 1'b1;
                ctrl.rs1_sel   = rs1_pc;
                ctrl.rs2_sel   = rs2_imm;
                ctrl.imm_sel   = imm_20u;
                imm            = instr[31:12];
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            ctrl.reg_write = 1'b0;  // never write on a bad encoding
        end
    end

endmodule

//--- regfile.sv
`timescale 1ns/1ps

module regfile #(
    parameter int nr_regs = 32
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    localparam int aw = $clog2(nr_regs);

    logic [31:0] regs [nr_regs];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < nr_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr[aw-1:0]] <= wdata;
        end
    end

    // x0 hard-wired
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1[aw-1:0]];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2[aw-1:0]];

    // rv32e has no x16..x31
    a_waddr_range: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> (int'(waddr) < nr_regs));

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  logic [xlen-1:0] d1,
    input  logic [xlen-1:0] d2,
    input  alu_op_e         op,
    output logic [xlen-1:0] res
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = d2[4:0];  // low 5 bits only

    assign lt_s = $signed(d1) < $signed(d2);
    assign lt_u = d1 < d2;

    always_comb begin
        case (op)
            alu_add:  res = d1 + d2;
            alu_sub:  res = d1 - d2;
            alu_sll:  res = d1 << shamt;
            alu_slt:  res = {{(xlen-1){1'b0}}, lt_s};
            alu_sltu: res = {{(xlen-1){1'b0}}, lt_u};
            alu_xor:  res = d1 ^ d2;
            alu_srl:  res = d1 >> shamt;
            alu_sra:  res = $unsigned($signed(d1) >>> shamt);  // keeps sign
            alu_or:   res = d1 | d2;
            alu_and:  res = d1 & d2;
            default:  res = '0;
        endcase
    end

endmodule

//--- exu.sv
`timescale 1ns/1ps

module exu import rv_pkg::*; (
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1_value,
    input  logic [xlen-1:0] rs2_value,
    input  logic [19:0]     imm,
    input  ex_ctrl_t        ctrl,
    output logic [xlen-1:0] ex_result
);

    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;

    // widen by format
    always_comb begin
        case (ctrl.imm_sel)
            imm_12i: imm_ext = {{(xlen-12){imm[11]}}, imm[11:0]};
            imm_20u: imm_ext = {imm, 12'd0};
            imm_5u:  imm_ext = {{(xlen-5){1'b0}}, imm[4:0]};
            default: imm_ext = '0;
        endcase
    end

    always_comb begin
        case (ctrl.rs1_sel)
            rs1_reg:  op1 = rs1_value;
            rs1_pc:   op1 = pc;         // auipc
            default:  op1 = '0;         // lui
        endcase
    end

    assign op2 = (ctrl.rs2_sel == rs2_reg) ? rs2_value : imm_ext;

    alu i_alu (
        .d1  (op1),
        .d2  (op2),
        .op  (ctrl.alu_op),
        .res (ex_result)
    );

    // decoder must never emit the spare selector code
    always_comb begin
        a_rs1_sel_known: assert (ctrl.rs1_sel inside {rs1_reg, rs1_pc, rs1_zero})
            else $error("exu: unused rs1_sel encoding %0d", ctrl.rs1_sel);
    end

endmodule

//--- exec_core.sv
`timescale 1ns/1ps

module exec_core import rv_pkg::*; #(
    parameter int nr_regs = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  logic [31:0]     instr,
    input  logic [31:0]     pc,
    output logic            wb_valid,
    output logic            wb_illegal,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_result
);

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [4:0]      rd;
    logic [19:0]     imm;
    ex_ctrl_t        ctrl;
    logic            illegal;
    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;
    logic [xlen-1:0] ex_result;
    logic            rf_we;

    idu i_idu (
        .instr    (instr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd       (rd),
        .imm      (imm),
        .ctrl     (ctrl),
        .illegal  (illegal)
    );

    // x0 writes dropped here as well as in the regfile
    assign rf_we = instr_valid && ctrl.reg_write && !illegal && (rd != 5'd0);

    regfile #(.nr_regs(nr_regs)) i_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (rf_we),
        .waddr  (rd),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .wdata  (ex_result),
        .rdata1 (rs1_value),
        .rdata2 (rs2_value)
    );

    exu i_exu (
        .pc        (pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .imm       (imm),
        .ctrl      (ctrl),
        .ex_result (ex_result)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid   <= 1'b0;
            wb_illegal <= 1'b0;
            wb_rd      <= '0;
            wb_result  <= '0;
        end else begin
            wb_valid   <= instr_valid && !illegal;
            wb_illegal <= instr_valid && illegal;
            if (instr_valid) begin
                wb_rd     <= rd;
                wb_result <= illegal ? '0 : ex_result;
            end
        end
    end

    a_wb_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_valid && wb_illegal));

endmodule

//--- tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 5;

    localparam logic [6:0] opc_op    = 7'b0110011;
    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_load  = 7'b0000011;  // not decoded by the core

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        illegal;
        logic [4:0]  rd;
        logic [31:0] result;
    } vec_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_valid;
    logic        wb_illegal;
    logic [4:0]  wb_rd;
    logic [31:0] wb_result;

    vec_t  vecs[$];
    string names[$];
    int    n_tests = 0;
    int    n_failed = 0;
    int    errors = 0;

    exec_core #(.nr_regs(32)) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb_valid    (wb_valid),
        .wb_illegal  (wb_illegal),
        .wb_rd       (wb_rd),
        .wb_result   (wb_result)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd);
        return {imm, rs1, f3, rd, opc_imm};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] enc_u(logic [6:0] opc, logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, opc};
    endfunction

    task automatic add_vec(input string name, input logic [31:0] ins, input logic [31:0] pcv,
                           input logic ill, input logic [4:0] rd, input logic [31:0] res);
        vec_t v;
        v.instr   = ins;
        v.pc      = pcv;
        v.illegal = ill;
        v.rd      = rd;
        v.result  = res;
        vecs.push_back(v);
        names.push_back(name);
    endtask

    // entries may read registers written by the entry before
    task automatic build_table();
        add_vec("addi x2,x1,5",     enc_i(12'd5, 5'd1, 3'b000, 5'd2), 32'h0, 1'b0, 5'd2, 32'h5);
        add_vec("addi x3,x0,-1",    enc_i(12'hfff, 5'd0, 3'b000, 5'd3), 32'h0, 1'b0, 5'd3,
                32'hffff_ffff);
        add_vec("addi x4,x0,-2048", enc_i(12'h800, 5'd0, 3'b000, 5'd4), 32'h0, 1'b0, 5'd4,
                32'hffff_f800);
        add_vec("lui x5",   enc_u(opc_lui, 20'habcde, 5'd5), 32'h0, 1'b0, 5'd5, 32'habcd_e000);
        add_vec("auipc x6", enc_u(opc_auipc, 20'h12345, 5'd6), 32'h1000, 1'b0, 5'd6,
                32'h1234_6000);
        add_vec("auipc x7", enc_u(opc_auipc, 20'hfffff, 5'd7), 32'h10, 1'b0, 5'd7,
                32'hffff_f010);
        add_vec("add x8",  enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd8), 32'h0, 1'b0, 5'd8, 32'h4);
        add_vec("sub x9",  enc_r(7'h20, 5'd2, 5'd8, 3'b000, 5'd9), 32'h0, 1'b0, 5'd9,
                32'hffff_ffff);
        add_vec("xor x10", enc_r(7'h00, 5'd5, 5'd9, 3'b100, 5'd10), 32'h0, 1'b0, 5'd10,
                32'h5432_1fff);
        add_vec("or x11",  enc_r(7'h00, 5'd6, 5'd10, 3'b110, 5'd11), 32'h0, 1'b0, 5'd11,
                32'h5636_7fff);
        add_vec("and x12", enc_r(7'h00, 5'd4, 5'd11, 3'b111, 5'd12), 32'h0, 1'b0, 5'd12,
                32'h5636_7800);
        add_vec("slli x13", enc_i(12'h004, 5'd2, 3'b001, 5'd13), 32'h0, 1'b0, 5'd13, 32'h50);
        add_vec("srli x14", enc_i(12'h008, 5'd5, 3'b101, 5'd14), 32'h0, 1'b0, 5'd14,
                32'h00ab_cde0);
        add_vec("srai x15", enc_i(12'h408, 5'd5, 3'b101, 5'd15), 32'h0, 1'b0, 5'd15,
                32'hffab_cde0);
        add_vec("addi x16,x0,36", enc_i(12'd36, 5'd0, 3'b000, 5'd16), 32'h0, 1'b0, 5'd16,
                32'd36);
        // 36 shifts by 4 only
        add_vec("sll x17", enc_r(7'h00, 5'd16, 5'd2, 3'b001, 5'd17), 32'h0, 1'b0, 5'd17, 32'h50);
        add_vec("sra x18", enc_r(7'h20, 5'd16, 5'd5, 3'b101, 5'd18), 32'h0, 1'b0, 5'd18,
                32'hfabc_de00);
        add_vec("srl x19", enc_r(7'h00, 5'd16, 5'd5, 3'b101, 5'd19), 32'h0, 1'b0, 5'd19,
                32'h0abc_de00);
        add_vec("slt x20",   enc_r(7'h00, 5'd2, 5'd3, 3'b010, 5'd20), 32'h0, 1'b0, 5'd20, 32'h1);
        add_vec("sltu x21",  enc_r(7'h00, 5'd2, 5'd3, 3'b011, 5'd21), 32'h0, 1'b0, 5'd21, 32'h0);
        add_vec("slti x22",  enc_i(12'd1, 5'd5, 3'b010, 5'd22), 32'h0, 1'b0, 5'd22, 32'h1);
        add_vec("sltiu x23", enc_i(12'hfff, 5'd2, 3'b011, 5'd23), 32'h0, 1'b0, 5'd23, 32'h1);
        add_vec("addi x0,x2,7", enc_i(12'd7, 5'd2, 3'b000, 5'd0), 32'h0, 1'b0, 5'd0, 32'hc);
        add_vec("add x24,x0,x2", enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd24), 32'h0, 1'b0, 5'd24,
                32'h5);
        add_vec("lw x5 (illegal)", {12'd4, 5'd2, 3'b010, 5'd5, opc_load}, 32'h0, 1'b1, 5'd5,
                32'h0);
        add_vec("mul x5 (illegal)", enc_r(7'h01, 5'd3, 5'd2, 3'b000, 5'd5), 32'h0, 1'b1, 5'd5,
                32'h0);
        add_vec("addi x25,x5,0", enc_i(12'd0, 5'd5, 3'b000, 5'd25), 32'h0, 1'b0, 5'd25,
                32'habcd_e000);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_entry(input int idx);
        int   errs_before;
        vec_t v;
        errs_before = errors;
        v = vecs[idx];
        check_value({names[idx], " wb_valid"}, 32'(wb_valid), 32'(!v.illegal));
        check_value({names[idx], " wb_illegal"}, 32'(wb_illegal), 32'(v.illegal));
        check_value({names[idx], " wb_rd"}, 32'(wb_rd), 32'(v.rd));
        if (!v.illegal) begin
            check_value({names[idx], " wb_result"}, wb_result, v.result);
        end
        if (errors != errs_before) n_failed++;
        $display("test %0d %s: %s", idx, names[idx], (errors == errs_before) ? "pass" : "FAIL");
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        build_table();
        n_tests = vecs.size();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("idle wb_valid", 32'(wb_valid), 32'h0);
        check_value("idle wb_illegal", 32'(wb_illegal), 32'h0);
        check_value("idle wb_rd", 32'(wb_rd), 32'h0);
        check_value("idle wb_result", wb_result, 32'h0);
        $display("idle after reset: %s", (errors == 0) ? "pass" : "FAIL");
        for (int i = 0; i < n_tests; i++) begin
            instr       = vecs[i].instr;
            pc          = vecs[i].pc;
            instr_valid = 1'b1;
            @(negedge clk);  // write-back one cycle later
            check_entry(i);
        end
        instr_valid = 1'b0;
        instr       = '0;
        @(negedge clk);
        check_value("drain wb_valid", 32'(wb_valid), 32'h0);
        $display("%0d of %0d tests passed, %0d mismatches", n_tests - n_failed, n_tests, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // generous bound on reset plus one cycle per entry
    initial begin
        wait (n_tests != 0);
        #((n_tests + reset_cycles + 20) * clk_period);
        $display("watchdog: simulation did not complete in time");
        $display("Something failed");
        $finish;
    end

endmodule

//--- sim.f
rv_pkg.sv
idu.sv
regfile.sv
alu.sv
exu.sv
exec_core.sv
tb_exec_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_exec_core
FILELIST  = sim.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || echo "Something failed" >> $(LOG)
	cat $(LOG)
	! grep -q "Something failed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
